// File: design/dcache_config.svh
////////////////////
// Data cache geometry macros
////////////////////

`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Associativity
`define DCACHE_WAYS 2

// Lines per way
`define DCACHE_LINES 16

// 32-bit words per line, also the fill burst length
`define DCACHE_LINE_WORDS 4

`endif

// File: design/dcache_pkg.sv
////////////////////
// Data cache types, port structs and address field helpers
////////////////////

`include "dcache_config.svh"

package dcache_pkg;

    localparam int LINE_W = $clog2(`DCACHE_LINES);
    localparam int WORD_W = $clog2(`DCACHE_LINE_WORDS);
    localparam int TAG_W  = 30 - LINE_W - WORD_W;

    typedef logic [31:0]              word_t;
    typedef logic [3:0]               byte_en_t;
    typedef logic [29:0]              word_addr_t;
    typedef logic [LINE_W-1:0]        line_idx_t;
    typedef logic [WORD_W-1:0]        word_idx_t;
    typedef logic [TAG_W-1:0]         tag_t;
    typedef logic [`DCACHE_WAYS-1:0]  way_mask_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef enum logic {
        REQ_READ,
        REQ_WRITE
    } req_kind_t;

    // Core side
    typedef struct packed {
        logic [31:0] addr;
        word_t       wdata;
        byte_en_t    be;
        logic        we;
    } ls_req_t;

    typedef struct packed {
        logic  data_valid;
        word_t data_out;
    } ls_rsp_t;

    // Memory side
    typedef struct packed {
        logic       request;
        logic       rnw;
        word_addr_t addr;
        byte_en_t   wbe;
        word_t      wdata;
    } mem_req_t;

    typedef struct packed {
        logic  ack;
        logic  rvalid;
        word_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic        inv;
        logic [31:0] inv_addr;
    } snoop_t;

    // Databank write port
    typedef struct packed {
        logic      wen;
        way_mask_t way;
        line_idx_t index;
        word_idx_t word;
        byte_en_t  be;
        word_t     data;
    } line_fill_t;

    ////////////////////
    // Byte address field extraction
    function automatic line_idx_t addr_idx(logic [31:0] addr);
        return addr[2+WORD_W +: LINE_W];
    endfunction

    function automatic tag_t addr_tag(logic [31:0] addr);
        return addr[2+WORD_W+LINE_W +: TAG_W];
    endfunction

    function automatic word_idx_t addr_word(logic [31:0] addr);
        return addr[2 +: WORD_W];
    endfunction

endpackage

// File: design/dcache_tagbank.sv
////////////////////
// Tag store with lookup and fill port, snoop port and start-up sweep
////////////////////

`include "dcache_config.svh"

module dcache_tagbank (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  lookup_en,
    input  dcache_pkg::line_idx_t lookup_idx,
    input  dcache_pkg::tag_t      lookup_tag,
    output dcache_pkg::way_mask_t hit_way,
    input  logic                  fill_en,
    input  dcache_pkg::line_idx_t fill_idx,
    input  dcache_pkg::way_mask_t fill_way,
    input  dcache_pkg::snoop_t    snoop,
    output logic                  snoop_busy,
    output logic                  sweeping
);
    import dcache_pkg::*;

    tag_entry_t [`DCACHE_WAYS-1:0] tag_mem [`DCACHE_LINES];

    tag_entry_t [`DCACHE_WAYS-1:0] a_rdata;
    tag_entry_t [`DCACHE_WAYS-1:0] b_rdata;
    tag_entry_t                    a_wdata;
    line_idx_t                     a_addr;
    way_mask_t                     a_wmask;

    logic      [LINE_W:0] sweep_cnt;
    line_idx_t            sweep_idx;

    logic      snoop_valid;
    logic      snoop_rd;
    logic      snoop_write;
    line_idx_t snoop_idx_r;
    tag_t      snoop_tag_r;
    way_mask_t snoop_hit;

    ////////////////////
    // Start-up sweep clears one line per cycle
    assign sweeping  = ~sweep_cnt[LINE_W];
    assign sweep_idx = sweep_cnt[LINE_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_cnt <= '0;
        end else if (sweeping) begin
            sweep_cnt <= sweep_cnt + 1'b1;
        end
    end

    ////////////////////
    // Snoop pipeline
    // Snoops are dropped while the sweep clears every tag
    assign snoop_rd = snoop.inv & ~sweeping;

    always_ff @(posedge clk) begin
        if (rst) begin
            snoop_valid <= 1'b0;
        end else begin
            snoop_valid <= snoop_rd;
        end
    end

    always_ff @(posedge clk) begin
        snoop_idx_r <= addr_idx(snoop.inv_addr);
        snoop_tag_r <= addr_tag(snoop.inv_addr);
    end

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            snoop_hit[w] = b_rdata[w].valid & (b_rdata[w].tag == snoop_tag_r);
            hit_way[w]   = a_rdata[w].valid & (a_rdata[w].tag == lookup_tag);
        end
    end

    assign snoop_write = snoop_valid & |snoop_hit;
    assign snoop_busy  = snoop_write;

    ////////////////////
    // Port A writes with snoop invalidation winning over a fill
    assign a_addr  = snoop_write ? snoop_idx_r : fill_idx;
    assign a_wmask = snoop_write ? snoop_hit : (fill_way & {`DCACHE_WAYS{fill_en}});
    assign a_wdata = snoop_write ? tag_entry_t'('0)
                                 : tag_entry_t'{valid: 1'b1, tag: lookup_tag};

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (a_wmask[w]) begin
                tag_mem[a_addr][w] <= a_wdata;
            end
        end
        // Port B clears during the sweep
        if (sweeping) begin
            tag_mem[sweep_idx] <= '0;
        end
        if (lookup_en) begin
            a_rdata <= tag_mem[lookup_idx];
        end
        if (snoop_rd) begin
            b_rdata <= tag_mem[addr_idx(snoop.inv_addr)];
        end
    end

endmodule

// File: design/dcache_databank.sv
////////////////////
// Data store with byte lanes and hit way read mux
////////////////////

`include "dcache_config.svh"

module dcache_databank (
    input  logic                   clk,
    input  logic                   rd_en,
    input  dcache_pkg::line_idx_t  rd_idx,
    input  dcache_pkg::word_idx_t  rd_word,
    input  dcache_pkg::way_mask_t  hit_way,
    input  dcache_pkg::line_fill_t fill,
    output dcache_pkg::word_t      rd_data
);
    import dcache_pkg::*;

    localparam int DEPTH = `DCACHE_LINES * `DCACHE_LINE_WORDS;

    logic [3:0][7:0] data_mem [`DCACHE_WAYS][DEPTH];

    word_t                   rd_ways [`DCACHE_WAYS];
    logic [LINE_W+WORD_W-1:0] rd_addr;
    logic [LINE_W+WORD_W-1:0] wr_addr;

    assign rd_addr = {rd_idx, rd_word};
    assign wr_addr = {fill.index, fill.word};

    always_ff @(posedge clk) begin
        if (fill.wen) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                for (int b = 0; b < 4; b++) begin
                    if (fill.way[w] & fill.be[b]) begin
                        data_mem[w][wr_addr][b] <= fill.data[8*b +: 8];
                    end
                end
            end
        end
        // All ways read together, the tag result picks one later
        if (rd_en) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                rd_ways[w] <= data_mem[w][rd_addr];
            end
        end
    end

    // One-hot select
    always_comb begin
        rd_data = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (hit_way[w]) begin
                rd_data |= rd_ways[w];
            end
        end
    end

endmodule

// File: design/dcache_control.sv
////////////////////
// Cache controller: stage 1 request, fills, writes, replacement
////////////////////

`include "dcache_config.svh"

module dcache_control (
    input  logic                   clk,
    input  logic                   rst,
    input  dcache_pkg::ls_req_t    ls_req,
    input  logic                   new_request,
    output logic                   ready,
    output dcache_pkg::ls_rsp_t    ls_rsp,
    output dcache_pkg::mem_req_t   mem_req,
    input  dcache_pkg::mem_rsp_t   mem_rsp,
    input  dcache_pkg::way_mask_t  hit_way,
    input  logic                   snoop_busy,
    input  logic                   sweeping,
    input  dcache_pkg::word_t      rd_data,
    output logic                   lookup_en,
    output dcache_pkg::line_idx_t  lookup_idx,
    output dcache_pkg::tag_t       lookup_tag,
    output logic                   fill_en,
    output dcache_pkg::line_idx_t  fill_idx,
    output dcache_pkg::way_mask_t  fill_way,
    output dcache_pkg::line_fill_t fill
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DECIDE,
        ST_MISS,
        ST_FILL,
        ST_WRITE
    } state_t;

    state_t    state;
    state_t    next_state;
    ls_req_t   stage1;
    req_kind_t stage1_kind;
    line_idx_t stage1_idx;
    word_idx_t stage1_word;
    logic      accept;
    logic      hit;
    logic      read_hit;
    logic      write_hit;
    logic      stage1_done;
    logic      filling;
    logic      last_beat;
    word_idx_t beat;
    way_mask_t replace_way;

    ////////////////////
    // Stage 1 capture
    assign accept = new_request & ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage1_kind <= REQ_READ;
        end else if (accept) begin
            stage1_kind <= ls_req.we ? REQ_WRITE : REQ_READ;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage1 <= ls_req;
        end
    end

    assign stage1_idx  = addr_idx(stage1.addr);
    assign stage1_word = addr_word(stage1.addr);

    // Tag and data lookups launch on the accept cycle
    assign lookup_en  = accept;
    assign lookup_idx = addr_idx(ls_req.addr);
    assign lookup_tag = addr_tag(stage1.addr);

    assign hit       = |hit_way;
    assign read_hit  = (state == ST_DECIDE) & (stage1_kind == REQ_READ) & hit;
    assign write_hit = (state == ST_DECIDE) & (stage1_kind == REQ_WRITE) & hit;
    assign filling   = (state == ST_FILL) & mem_rsp.rvalid;
    assign last_beat = filling & (beat == word_idx_t'(`DCACHE_LINE_WORDS - 1));

    ////////////////////
    // Request FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    next_state = ST_DECIDE;
                end
            end
            ST_DECIDE: begin
                // Writes always go through to memory
                if (stage1_kind == REQ_WRITE) begin
                    next_state = ST_WRITE;
                end else if (hit) begin
                    next_state = accept ? ST_DECIDE : ST_IDLE;
                end else begin
                    next_state = ST_MISS;
                end
            end
            ST_MISS: begin
                if (mem_rsp.ack) begin
                    next_state = ST_FILL;
                end
            end
            ST_FILL: begin
                if (last_beat) begin
                    next_state = ST_IDLE;
                end
            end
            ST_WRITE: begin
                if (mem_rsp.ack) begin
                    next_state = accept ? ST_DECIDE : ST_IDLE;
                end
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    // Fill ends in IDLE so a following read sees the last word written
    assign stage1_done = read_hit | ((state == ST_WRITE) & mem_rsp.ack);
    assign ready = ~sweeping & ~snoop_busy & ((state == ST_IDLE) | stage1_done);

    ////////////////////
    // Burst beat counter
    always_ff @(posedge clk) begin
        if (rst) begin
            beat <= '0;
        end else if (state != ST_FILL) begin
            beat <= '0;
        end else if (mem_rsp.rvalid) begin
            beat <= beat + 1'b1;
        end
    end

    // Replacement cycler, rotates on every accepted request
    always_ff @(posedge clk) begin
        if (rst) begin
            replace_way <= way_mask_t'(1);
        end else if (accept) begin
            replace_way <= {replace_way[`DCACHE_WAYS-2:0], replace_way[`DCACHE_WAYS-1]};
        end
    end

    ////////////////////
    // Memory port
    // Reads fetch from word 0 of the line
    assign mem_req = '{
        request: (state == ST_MISS) | (state == ST_WRITE),
        rnw:     stage1_kind == REQ_READ,
        addr:    (stage1_kind == REQ_READ) ?
                 {stage1.addr[31:2+WORD_W], {WORD_W{1'b0}}} : stage1.addr[31:2],
        wbe:     stage1.be,
        wdata:   stage1.wdata
    };

    // Tag is set on the ack, before the data beats arrive
    assign fill_en  = (state == ST_MISS) & mem_rsp.ack;
    assign fill_idx = stage1_idx;
    assign fill_way = replace_way;

    ////////////////////
    // Databank writes and core response
    assign fill = '{
        wen:   write_hit | filling,
        way:   (state == ST_FILL) ? replace_way : hit_way,
        index: stage1_idx,
        word:  (state == ST_FILL) ? beat : stage1_word,
        be:    (state == ST_FILL) ? byte_en_t'('1) : stage1.be,
        data:  (state == ST_FILL) ? mem_rsp.rdata : stage1.wdata
    };

    assign ls_rsp = '{
        data_valid: read_hit | (filling & (beat == stage1_word)),
        data_out:   (state == ST_DECIDE) ? rd_data : mem_rsp.rdata
    };

endmodule

// File: design/dcache_top.sv
////////////////////
// Data cache top level
////////////////////

module dcache_top (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::ls_req_t  ls_req,
    input  logic                 new_request,
    output logic                 ready,
    output dcache_pkg::ls_rsp_t  ls_rsp,
    output dcache_pkg::mem_req_t mem_req,
    input  dcache_pkg::mem_rsp_t mem_rsp,
    input  dcache_pkg::snoop_t   snoop
);
    import dcache_pkg::*;

    way_mask_t  hit_way;
    logic       snoop_busy;
    logic       sweeping;
    word_t      rd_data;
    logic       lookup_en;
    line_idx_t  lookup_idx;
    tag_t       lookup_tag;
    word_idx_t  lookup_word;
    logic       fill_en;
    line_idx_t  fill_idx;
    way_mask_t  fill_way;
    line_fill_t fill;

    // Databank reads the word on the same cycle as the tag lookup
    assign lookup_word = addr_word(ls_req.addr);

    dcache_tagbank tagbank_i (
        .clk        (clk),
        .rst        (rst),
        .lookup_en  (lookup_en),
        .lookup_idx (lookup_idx),
        .lookup_tag (lookup_tag),
        .hit_way    (hit_way),
        .fill_en    (fill_en),
        .fill_idx   (fill_idx),
        .fill_way   (fill_way),
        .snoop      (snoop),
        .snoop_busy (snoop_busy),
        .sweeping   (sweeping)
    );

    dcache_databank databank_i (
        .clk     (clk),
        .rd_en   (lookup_en),
        .rd_idx  (lookup_idx),
        .rd_word (lookup_word),
        .hit_way (hit_way),
        .fill    (fill),
        .rd_data (rd_data)
    );

    dcache_control control_i (
        .clk         (clk),
        .rst         (rst),
        .ls_req      (ls_req),
        .new_request (new_request),
        .ready       (ready),
        .ls_rsp      (ls_rsp),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .hit_way     (hit_way),
        .snoop_busy  (snoop_busy),
        .sweeping    (sweeping),
        .rd_data     (rd_data),
        .lookup_en   (lookup_en),
        .lookup_idx  (lookup_idx),
        .lookup_tag  (lookup_tag),
        .fill_en     (fill_en),
        .fill_idx    (fill_idx),
        .fill_way    (fill_way),
        .fill        (fill)
    );

endmodule

// File: test/dcache_props.sv
////////////////////
// Handshake and start-up assertions bound to the cache top level
////////////////////

`include "dcache_config.svh"

module dcache_props (
    input logic                 clk,
    input logic                 rst,
    input logic                 new_request,
    input logic                 ready,
    input logic                 sweeping,
    input dcache_pkg::mem_req_t mem_req,
    input dcache_pkg::mem_rsp_t mem_rsp
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // Core only raises a request when the cache can take it
    request_needs_ready: assert property (
        @(posedge clk) disable iff (rst) new_request |-> ready
    ) else begin
        $error("new_request high while ready is low");
        fail_count++;
    end

    // Memory only acks a pending request
    ack_needs_request: assert property (
        @(posedge clk) disable iff (rst) mem_rsp.ack |-> mem_req.request
    ) else begin
        $error("memory ack without a request");
        fail_count++;
    end

    // Ready low as the sweep starts and high once every line is cleared
    ready_after_sweep: assert property (
        @(posedge clk) disable iff (rst)
        $fell(rst) |-> !ready ## `DCACHE_LINES (ready && !sweeping)
    ) else begin
        $error("ready wrong at the start or the end of the tag sweep");
        fail_count++;
    end

    // Request fields hold until the ack
    request_held: assert property (
        @(posedge clk) disable iff (rst)
        mem_req.request && !mem_rsp.ack |=> mem_req.request && $stable(mem_req)
    ) else begin
        $error("memory request dropped or changed before ack");
        fail_count++;
    end

endmodule

// File: test/dcache_tb.sv
////////////////////
// Data cache testbench with memory model, stimulus table and checks
////////////////////

`include "dcache_config.svh"

module dcache_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_pkg::*;

    localparam int SWEEP_TIMEOUT = 4 * `DCACHE_LINES;
    localparam int READY_TIMEOUT = 50;
    localparam int DATA_TIMEOUT  = 50;
    localparam int MEM_WORDS     = 1024;

    typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_SNOOP} op_t;
    typedef enum logic [1:0] {EXP_HIT, EXP_MISS, EXP_ANY} hit_exp_t;

    typedef struct {
        op_t         op;
        logic [31:0] addr;
        word_t       data;
        byte_en_t    be;
        word_t       expected;
        hit_exp_t    miss;
    } step_t;

    logic     clk = 1'b0;
    logic     rst;
    ls_req_t  ls_req;
    logic     new_request;
    logic     ready;
    ls_rsp_t  ls_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    snoop_t   snoop;

    word_t       mem_model [MEM_WORDS];
    int          read_req_count = 0;
    int          write_req_count = 0;
    word_addr_t  last_read_addr;
    mem_req_t    last_write_req;
    logic [31:0] rand_state = 32'd65409;
    step_t       steps [$];

    dcache_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .ls_req      (ls_req),
        .new_request (new_request),
        .ready       (ready),
        .ls_rsp      (ls_rsp),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .snoop       (snoop)
    );

    bind dcache_top dcache_props props_i (
        .clk         (clk),
        .rst         (rst),
        .new_request (new_request),
        .ready       (ready),
        .sweeping    (sweeping),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp)
    );

    always #10 clk = ~clk;

    ////////////////////
    // Helpers
    function automatic logic [31:0] xorshift_next(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Initial memory contents depend on every word address bit
    function automatic word_t pattern_word(logic [31:0] byte_addr);
        logic [9:0] w;
        w = byte_addr[11:2];
        return {w[5:0], 6'h2d, ~w, w};
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t wdata, byte_en_t be);
        word_t result;
        result = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                result[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return result;
    endfunction

    task automatic stop_failed();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first failing check");
    endtask

    task automatic report_error(string msg);
        $display("error at %0d ns: %s", $time, msg);
        stop_failed();
    endtask

    task automatic report_timeout(string msg);
        $display("timeout at %0d ns: %s", $time, msg);
        stop_failed();
    endtask

    ////////////////////
    // Compare tasks
    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp) begin
            report_error($sformatf("%s returned 0x%08h, expected 0x%08h", what, got, exp));
        end
    endtask

    task automatic check_addr(word_addr_t got, word_addr_t exp, string what);
        if (got !== exp) begin
            report_error($sformatf("%s fetched word address 0x%08h, expected 0x%08h",
                                   what, got, exp));
        end
    endtask

    task automatic check_mem_req(mem_req_t got, mem_req_t exp, string what);
        if (got !== exp) begin
            report_error($sformatf("%s sent rnw %b addr 0x%08h wbe %b wdata 0x%08h, %s",
                                   what, got.rnw, got.addr, got.wbe, got.wdata,
                                   $sformatf("expected rnw %b addr 0x%08h wbe %b wdata 0x%08h",
                                             exp.rnw, exp.addr, exp.wbe, exp.wdata)));
        end
    endtask

    ////////////////////
    // Stimulus table
    function automatic void add_step(op_t op, logic [31:0] addr, word_t data, byte_en_t be,
                                     word_t expected, hit_exp_t miss);
        step_t s;
        s.op       = op;
        s.addr     = addr;
        s.data     = data;
        s.be       = be;
        s.expected = expected;
        s.miss     = miss;
        steps.push_back(s);
    endfunction

    function automatic void build_steps();
        word_t merged_128;
        merged_128 = merge_bytes(pattern_word(32'h128), 32'hdead_beef, 4'b0110);
        // Miss then hits on the same line
        add_step(OP_READ, 32'h124, '0, '0, pattern_word(32'h124), EXP_MISS);
        add_step(OP_READ, 32'h124, '0, '0, pattern_word(32'h124), EXP_HIT);
        add_step(OP_READ, 32'h12c, '0, '0, pattern_word(32'h12c), EXP_HIT);
        // Partial write hit and a read back of the merged word
        add_step(OP_WRITE, 32'h128, 32'hdead_beef, 4'b0110, '0, EXP_ANY);
        add_step(OP_READ, 32'h128, '0, '0, merged_128, EXP_HIT);
        // Write miss must not allocate
        add_step(OP_WRITE, 32'h300, 32'h1234_5678, 4'b1001, '0, EXP_ANY);
        add_step(OP_READ, 32'h300, '0, '0,
                 merge_bytes(pattern_word(32'h300), 32'h1234_5678, 4'b1001), EXP_MISS);
        // Memory changed behind the cache and then snooped
        add_step(OP_SNOOP, 32'h124, 32'hcafe_f00d, 4'b1111, '0, EXP_ANY);
        add_step(OP_READ, 32'h124, '0, '0, 32'hcafe_f00d, EXP_MISS);
        add_step(OP_READ, 32'h128, '0, '0, merged_128, EXP_HIT);
        // Three tags on index 4 in a 2-way set
        add_step(OP_READ, 32'h040, '0, '0, pattern_word(32'h040), EXP_MISS);
        add_step(OP_READ, 32'h144, '0, '0, pattern_word(32'h144), EXP_MISS);
        add_step(OP_READ, 32'h248, '0, '0, pattern_word(32'h248), EXP_MISS);
        add_step(OP_READ, 32'h04c, '0, '0, pattern_word(32'h04c), EXP_ANY);
        add_step(OP_READ, 32'h140, '0, '0, pattern_word(32'h140), EXP_ANY);
        add_step(OP_READ, 32'h244, '0, '0, pattern_word(32'h244), EXP_ANY);
        add_step(OP_SNOOP, 32'h148, 32'h0bad_cafe, 4'b0011, '0, EXP_ANY);
        add_step(OP_READ, 32'h148, '0, '0,
                 merge_bytes(pattern_word(32'h148), 32'h0bad_cafe, 4'b0011), EXP_MISS);
        add_step(OP_READ, 32'h14c, '0, '0, pattern_word(32'h14c), EXP_HIT);
        add_step(OP_WRITE, 32'h04c, 32'h55aa_55aa, 4'b1000, '0, EXP_ANY);
        add_step(OP_READ, 32'h04c, '0, '0,
                 merge_bytes(pattern_word(32'h04c), 32'h55aa_55aa, 4'b1000), EXP_ANY);
    endfunction

    ////////////////////
    // Core side driving
    task automatic issue_request(step_t s);
        int guard;
        guard = 0;
        @(negedge clk);
        while (!ready) begin
            guard++;
            if (guard > READY_TIMEOUT) begin
                report_timeout("ready stayed low while a request was waiting");
            end
            @(negedge clk);
        end
        @(posedge clk);
        ls_req      <= '{addr: s.addr, wdata: s.data, be: s.be, we: s.op == OP_WRITE};
        new_request <= 1'b1;
        // Accepted at this edge
        @(posedge clk);
        new_request <= 1'b0;
    endtask

    task automatic wait_read_data(output int latency, output word_t got, input string what);
        latency = 1;
        @(negedge clk);
        while (!ls_rsp.data_valid) begin
            latency++;
            if (latency > DATA_TIMEOUT) begin
                report_timeout({"no read data arrived for ", what});
            end
            @(negedge clk);
        end
        got = ls_rsp.data_out;
    endtask

    task automatic wait_ready(string what);
        int guard;
        guard = 0;
        while (!ready) begin
            guard++;
            if (guard > READY_TIMEOUT) begin
                report_timeout({"ready did not return after ", what});
            end
            @(negedge clk);
        end
    endtask

    task automatic send_snoop(step_t s);
        int idx;
        idx = int'(s.addr[11:2]);
        mem_model[idx] = merge_bytes(mem_model[idx], s.data, s.be);
        @(posedge clk);
        snoop <= '{inv: 1'b1, inv_addr: s.addr};
        @(posedge clk);
        snoop.inv <= 1'b0;
        // Lookup and tag write take the next two cycles
        repeat (3) @(posedge clk);
    endtask

    task automatic run_read(step_t s, int n);
        int    rd_before;
        int    wr_before;
        int    latency;
        word_t got;
        string what;
        what      = $sformatf("step %0d read of 0x%08h", n, s.addr);
        rd_before = read_req_count;
        wr_before = write_req_count;
        issue_request(s);
        wait_read_data(latency, got, what);
        check_word(got, s.expected, what);
        wait_ready(what);
        if (write_req_count != wr_before) begin
            report_error({what, " issued a memory write"});
        end
        if (s.miss == EXP_HIT) begin
            if (read_req_count != rd_before) begin
                report_error({what, " should hit but went to memory"});
            end
            if (latency != 1) begin
                report_error($sformatf("%s hit data came %0d cycles after accept",
                                       what, latency));
            end
        end else if (read_req_count == rd_before + 1) begin
            check_addr(last_read_addr, {s.addr[31:4], 2'b00}, what);
        end else if (s.miss == EXP_MISS || read_req_count != rd_before) begin
            report_error($sformatf("%s issued %0d line reads, expected one",
                                   what, read_req_count - rd_before));
        end
    endtask

    task automatic run_write(step_t s, int n);
        int       rd_before;
        int       wr_before;
        mem_req_t expected;
        string    what;
        what      = $sformatf("step %0d write of 0x%08h", n, s.addr);
        rd_before = read_req_count;
        wr_before = write_req_count;
        expected  = '{request: 1'b1, rnw: 1'b0, addr: s.addr[31:2], wbe: s.be, wdata: s.data};
        issue_request(s);
        @(negedge clk);
        wait_ready(what);
        if (write_req_count != wr_before + 1) begin
            report_error($sformatf("%s issued %0d memory writes, expected one",
                                   what, write_req_count - wr_before));
        end
        check_mem_req(last_write_req, expected, what);
        if (read_req_count != rd_before) begin
            report_error({what, " fetched a line"});
        end
    endtask

    // Ready stays low for one cycle per line after reset with no memory traffic
    task automatic check_sweep();
        int low_cycles;
        low_cycles = 0;
        @(negedge clk);
        while (!ready) begin
            if (mem_req.request || ls_rsp.data_valid) begin
                report_error("memory request or read data during the tag sweep");
            end
            low_cycles++;
            if (low_cycles > SWEEP_TIMEOUT) begin
                report_timeout("ready never rose after the tag sweep");
            end
            @(negedge clk);
        end
        if (low_cycles != `DCACHE_LINES) begin
            report_error($sformatf("ready low for %0d cycles after reset, expected %0d",
                                   low_cycles, `DCACHE_LINES));
        end
        if (read_req_count + write_req_count != 0) begin
            report_error("memory request seen before the sweep finished");
        end
    endtask

    ////////////////////
    // Memory model
    initial begin : memory_model
        mem_req_t req;
        int       delay;
        int       base;
        mem_rsp = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_model[i] = pattern_word(32'(i) << 2);
        end
        forever begin
            @(negedge clk);
            if (mem_req.request) begin
                req  = mem_req;
                base = int'(req.addr[9:0]);
                if (req.rnw) begin
                    read_req_count++;
                    last_read_addr = req.addr;
                end else begin
                    write_req_count++;
                    last_write_req = req;
                end
                rand_state = xorshift_next(rand_state);
                delay      = int'(rand_state[1:0]);
                repeat (delay) @(posedge clk);
                @(posedge clk);
                mem_rsp.ack <= 1'b1;
                if (!req.rnw) begin
                    mem_model[base] = merge_bytes(mem_model[base], req.wdata, req.wbe);
                end
                @(posedge clk);
                mem_rsp.ack <= 1'b0;
                if (req.rnw) begin
                    rand_state = xorshift_next(rand_state);
                    delay      = int'(rand_state[1:0]);
                    repeat (delay) @(posedge clk);
                    // Whole line from word 0 at one beat per cycle
                    for (int b = 0; b < `DCACHE_LINE_WORDS; b++) begin
                        mem_rsp.rvalid <= 1'b1;
                        mem_rsp.rdata  <= mem_model[base + b];
                        @(posedge clk);
                    end
                    mem_rsp.rvalid <= 1'b0;
                    mem_rsp.rdata  <= '0;
                end
            end
        end
    end

    ////////////////////
    // Main sequence
    initial begin : main_sequence
        rst         = 1'b1;
        new_request = 1'b0;
        ls_req      = '0;
        snoop       = '0;
        build_steps();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        check_sweep();
        foreach (steps[i]) begin
            case (steps[i].op)
                OP_READ:  run_read(steps[i], i);
                OP_WRITE: run_write(steps[i], i);
                default:  send_snoop(steps[i]);
            endcase
        end
        repeat (2) @(posedge clk);
        if (dut_i.props_i.fail_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("%0d handshake assertions failed", dut_i.props_i.fail_count);
            stop_failed();
        end
    end

endmodule

// File: build.f
+incdir+design
design/dcache_pkg.sv
design/dcache_tagbank.sv
design/dcache_databank.sv
design/dcache_control.sv
design/dcache_top.sv
test/dcache_props.sv
test/dcache_tb.sv
